// ==== rom_slot_config.svh ====
`ifndef ROM_SLOT_CONFIG_SVH
`define ROM_SLOT_CONFIG_SVH

// sdram word address width
`define SDRAM_AW    22

// client address widths
`define SND_AW      15 // byte address
`define MAIN_AW     17 // byte address
`define CHAR_AW     13
`define OBJ_AW      16
`define SCR_AW      15

// rom regions inside the sdram, in words
`define SND_OFFSET  'h0A000
`define CHAR_OFFSET 'h0E000
`define SCR_OFFSET  'h10000
`define SCR2_OFFSET 'h08000 // distance from scroll low word to its upper byte
`define OBJ_OFFSET  'h20000

// enables from end of reset or download until ready
`define READY_DELAY 5

`endif

// ==== rom_slot_pkg.sv ====
package rom_slot_pkg;

    // owner of one time slot on the shared sdram read port
    typedef enum logic [2:0] {
        client_snd    = 3'd0, // sound cpu, byte wide
        client_main   = 3'd1, // main cpu, byte wide
        client_char   = 3'd2, // character tiles
        client_obj    = 3'd3, // object sprites
        client_scr_lo = 3'd4, // scroll tile, first word
        client_scr_hi = 3'd5, // scroll tile, second word
        client_idle   = 3'd6  // free slot, nothing read
    } rom_client_e;

    // decoded slot, 8 bits
    typedef struct packed {
        logic [3:0]  slot;       // {h, hsub}
        rom_client_e client;
        logic        refresh_ok; // char and scroll slots may host autorefresh
    } slot_info_t;

    // read in flight between address and data stages, 4 bits
    typedef struct packed {
        rom_client_e client;
        logic        byte_lsb; // byte lane for the 8-bit cpus
    } issue_info_t;

    // client output registers, 72 bits
    typedef struct packed {
        logic [7:0]  snd_dout;
        logic [7:0]  main_dout;
        logic [15:0] char_dout;
        logic [15:0] obj_dout;
        logic [23:0] scr_dout; // {upper byte, two lower bytes}
    } rom_outputs_t;

endpackage

// ==== rom_slot_decode.sv ====
module rom_slot_decode import rom_slot_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cen,
    input  logic [2:0] h,
    input  logic       hsub,
    output slot_info_t cur_slot
);

    logic [3:0]  slot;      // half-pixel position inside the 8-pixel group
    rom_client_e client;
    slot_info_t  prev_slot; // slot seen at the last enable

    assign slot = {h, hsub};

    // cpus take every fourth slot, the rest is shared by the video roms
    always_comb begin
        client = client_idle;
        case (slot[1:0])
            2'b00: client = client_snd;
            2'b01: client = client_main;
            default: begin
                case (slot)
                    4'd2:        client = client_char;
                    4'd3, 4'd11: client = client_obj; // two sprite reads per group
                    4'd6:        client = client_scr_lo;
                    4'd7:        client = client_scr_hi;
                    default:     client = client_idle; // 10, 14, 15
                endcase
            end
        endcase
    end

    assign cur_slot.slot       = slot;
    assign cur_slot.client     = client;
    assign cur_slot.refresh_ok = (client == client_char) || (client == client_scr_lo)
                               || (client == client_scr_hi);

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_slot <= '0; // slot 0 belongs to the sound cpu
        end else if (cen) begin
            prev_slot <= cur_slot;
        end
    end

    // free slots are exactly 10, 14 and 15 of the group
    a_idle_slots: assert property (@(posedge clk) disable iff (reset)
        (prev_slot.client == client_idle) ==
        (prev_slot.slot inside {4'd10, 4'd14, 4'd15}));

endmodule

// ==== rom_addr_issue.sv ====
`include "rom_slot_config.svh"

module rom_addr_issue import rom_slot_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cen,
    input  logic                 downloading,
    input  logic                 lvbl,
    input  slot_info_t           cur_slot,
    input  logic [`SND_AW-1:0]   snd_addr,
    input  logic [`MAIN_AW-1:0]  main_addr,
    input  logic [`CHAR_AW-1:0]  char_addr,
    input  logic [`OBJ_AW-1:0]   obj_addr,
    input  logic [`SCR_AW-1:0]   scr_addr,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    output logic                 autorefresh,
    output issue_info_t          issue
);

    localparam logic [`SDRAM_AW-1:0] snd_offset  = `SND_OFFSET;
    localparam logic [`SDRAM_AW-1:0] char_offset = `CHAR_OFFSET;
    localparam logic [`SDRAM_AW-1:0] scr_offset  = `SCR_OFFSET;
    localparam logic [`SDRAM_AW-1:0] scr2_offset = `SCR2_OFFSET;
    localparam logic [`SDRAM_AW-1:0] obj_offset  = `OBJ_OFFSET;

    // client addresses widened to the sdram word address
    logic [`SDRAM_AW-1:0] snd_word;
    logic [`SDRAM_AW-1:0] main_word;
    logic [`SDRAM_AW-1:0] char_word;
    logic [`SDRAM_AW-1:0] obj_word;
    logic [`SDRAM_AW-1:0] scr_word;
    logic [`SDRAM_AW-1:0] addr_next;
    logic                 lsb_next;

    assign snd_word  = {{(`SDRAM_AW-`SND_AW+1){1'b0}}, snd_addr[`SND_AW-1:1]};   // byte to word
    assign main_word = {{(`SDRAM_AW-`MAIN_AW+1){1'b0}}, main_addr[`MAIN_AW-1:1]};
    assign char_word = {{(`SDRAM_AW-`CHAR_AW){1'b0}}, char_addr};
    assign obj_word  = {{(`SDRAM_AW-`OBJ_AW){1'b0}}, obj_addr};
    assign scr_word  = {{(`SDRAM_AW-`SCR_AW){1'b0}}, scr_addr};

    always_comb begin
        addr_next = sdram_addr; // idle slots keep the last address
        lsb_next  = 1'b0;
        case (cur_slot.client)
            client_snd: begin
                addr_next = snd_offset + snd_word;
                lsb_next  = snd_addr[0]; // picks the byte when data returns
            end
            client_main: begin
                addr_next = main_word; // main cpu rom sits at the bottom
                lsb_next  = main_addr[0];
            end
            client_char:   addr_next = char_offset + char_word;
            client_obj:    addr_next = obj_offset + obj_word;
            client_scr_lo: addr_next = scr_offset + scr_word;
            // upper tile byte lives a fixed distance above the low word
            client_scr_hi: addr_next = sdram_addr + scr2_offset;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            sdram_addr     <= '0;
            autorefresh    <= 1'b0;
            issue.client   <= client_idle; // nothing in flight
            issue.byte_lsb <= 1'b0;
        end else if (cen) begin
            sdram_addr     <= addr_next;
            // refresh only in vblank, and only where the slot allows it
            autorefresh    <= !lvbl && cur_slot.refresh_ok;
            issue.client   <= cur_slot.client;
            issue.byte_lsb <= lsb_next;
        end
    end

    // no refresh request is ever seen during active video
    a_refresh_vblank: assert property (@(posedge clk) disable iff (reset || downloading)
        lvbl |-> !autorefresh);

endmodule

// ==== rom_data_capture.sv ====
`include "rom_slot_config.svh"

module rom_data_capture import rom_slot_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         cen,
    input  logic         downloading,
    input  issue_info_t  issue,
    input  logic [15:0]  data_read,
    output rom_outputs_t roms,
    output logic         ready
);

    logic [15:0]             scr_aux;  // first scroll word, waits for the second
    logic [`READY_DELAY-2:0] ready_sr; // ones shift in, ready is the last stage
    logic [7:0]              byte_sel;
    logic [7:0]              hi_byte;

    // lsb 0 means the upper byte of the word
    assign byte_sel = issue.byte_lsb ? data_read[7:0] : data_read[15:8];

    // upper tile byte, only one half of the word carries data
    assign hi_byte = data_read[15:8] | data_read[7:0];

    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            roms     <= '0;
            scr_aux  <= '0;
            ready_sr <= '0;
            ready    <= 1'b0;
        end else if (cen) begin
            {ready, ready_sr} <= {ready_sr, 1'b1};
            case (issue.client)
                client_snd:    roms.snd_dout  <= byte_sel;
                client_main:   roms.main_dout <= byte_sel;
                client_char:   roms.char_dout <= data_read;
                client_obj:    roms.obj_dout  <= data_read;
                client_scr_lo: scr_aux        <= data_read; // held for the second word
                client_scr_hi: roms.scr_dout  <= {hi_byte, scr_aux};
                default: ;     // idle drops the word
            endcase
        end
    end

    // reset always leaves the core not ready
    a_ready_reset: assert property (@(posedge clk)
        reset |=> !ready);

endmodule

// ==== rom_slot_top.sv ====
`include "rom_slot_config.svh"

module rom_slot_top import rom_slot_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cen,
    input  logic [2:0]           h,
    input  logic                 hsub,
    input  logic                 lvbl,
    input  logic                 downloading,
    input  logic [`SND_AW-1:0]   snd_addr,
    input  logic [`MAIN_AW-1:0]  main_addr,
    input  logic [`CHAR_AW-1:0]  char_addr,
    input  logic [`OBJ_AW-1:0]   obj_addr,
    input  logic [`SCR_AW-1:0]   scr_addr,
    input  logic [15:0]          data_read,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    output logic                 autorefresh,
    output logic                 ready,
    output rom_outputs_t         roms
);

    slot_info_t  cur_slot; // decoded slot for this enable
    issue_info_t issue;    // read whose data arrives at the next enable

    rom_slot_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .cen      (cen),
        .h        (h),
        .hsub     (hsub),
        .cur_slot (cur_slot)
    );

    rom_addr_issue u_issue (
        .clk         (clk),
        .reset       (reset),
        .cen         (cen),
        .downloading (downloading),
        .lvbl        (lvbl),
        .cur_slot    (cur_slot),
        .snd_addr    (snd_addr),
        .main_addr   (main_addr),
        .char_addr   (char_addr),
        .obj_addr    (obj_addr),
        .scr_addr    (scr_addr),
        .sdram_addr  (sdram_addr),
        .autorefresh (autorefresh),
        .issue       (issue)
    );

    rom_data_capture u_capture (
        .clk         (clk),
        .reset       (reset),
        .cen         (cen),
        .downloading (downloading),
        .issue       (issue),
        .data_read   (data_read),
        .roms        (roms),
        .ready       (ready)
    );

endmodule

// ==== tb_sdram_model.sv ====
`include "rom_slot_config.svh"

module tb_sdram_model (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`SDRAM_AW-1:0] addr,
    output logic [15:0]          data
);

    logic [15:0] word_next;

    // even words carry the address byte on top, odd words at the bottom
    always_comb begin
        if (addr[0]) begin
            word_next = {8'h00, addr[7:0]};
        end else begin
            word_next = {addr[7:0], 8'h00};
        end
    end

    // one clock of read latency, well inside the two clocks between enables
    always_ff @(posedge clk) begin
        if (reset) begin
            data <= '0;
        end else begin
            data <= word_next;
        end
    end

endmodule

// ==== tb_rom_slot.sv ====
`include "rom_slot_config.svh"

module tb_rom_slot import rom_slot_pkg::*; ();

    // six tests of about 16 slots at 2 clocks each, with a wide margin
    localparam int test_cycles    = 6 * 16 * 2;
    localparam int timeout_cycles = 10 * test_cycles; // about 2000 cycles

    logic                 clk;
    logic                 reset;
    logic                 cen;
    logic [2:0]           h;
    logic                 hsub;
    logic                 lvbl;
    logic                 downloading;
    logic [`SND_AW-1:0]   snd_addr;
    logic [`MAIN_AW-1:0]  main_addr;
    logic [`CHAR_AW-1:0]  char_addr;
    logic [`OBJ_AW-1:0]   obj_addr;
    logic [`SCR_AW-1:0]   scr_addr;
    logic [15:0]          data_read;
    logic [`SDRAM_AW-1:0] sdram_addr;
    logic                 autorefresh;
    logic                 ready;
    rom_outputs_t         roms;

    integer     seed = 18108;
    int         err_count;
    int         test_err_start;
    int         tests_run;
    int         tests_failed;
    int         cycle_count;
    logic [3:0] slot_num; // slot driven at the next enable

    rom_slot_top uut (
        .clk         (clk),
        .reset       (reset),
        .cen         (cen),
        .h           (h),
        .hsub        (hsub),
        .lvbl        (lvbl),
        .downloading (downloading),
        .snd_addr    (snd_addr),
        .main_addr   (main_addr),
        .char_addr   (char_addr),
        .obj_addr    (obj_addr),
        .scr_addr    (scr_addr),
        .data_read   (data_read),
        .sdram_addr  (sdram_addr),
        .autorefresh (autorefresh),
        .ready       (ready),
        .roms        (roms)
    );

    tb_sdram_model u_sdram (
        .clk   (clk),
        .reset (reset),
        .addr  (sdram_addr),
        .data  (data_read)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // word the memory model returns for a word address
    function automatic logic [15:0] model_word(input logic [`SDRAM_AW-1:0] a);
        return a[0] ? {8'h00, a[7:0]} : {a[7:0], 8'h00};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_word(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_scr(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_addr(input string name, input logic [`SDRAM_AW-1:0] got,
                                input logic [`SDRAM_AW-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_roms(input string name, input rom_outputs_t got,
                                input rom_outputs_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count == test_err_start) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, err_count - test_err_start);
            tests_failed++;
        end
        test_err_start = err_count;
    endtask

    // one enable period, slot held across the enable edge
    task automatic next_enable();
        @(posedge clk);
        #1;
        cen  = 1'b1;
        {h, hsub} = slot_num;
        @(posedge clk); // stage 2 loads this slot, stage 3 takes the last one
        #1;
        cen      = 1'b0;
        slot_num = slot_num + 1'b1;
    endtask

    task automatic run_to_slot(input logic [3:0] target);
        while (slot_num != target) begin
            next_enable();
        end
    endtask

    // ready must rise on exactly the READY_DELAY-th enable
    task automatic check_ready_rise();
        for (int i = 1; i <= `READY_DELAY; i++) begin
            next_enable();
            compare_flag("ready", ready, i >= `READY_DELAY);
        end
    endtask

    task automatic test_reset_ready();
        reset = 1'b1;
        cen   = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        compare_flag("ready", ready, 1'b0); // still in reset
        reset    = 1'b0;
        slot_num = '0;
        compare_roms("roms", roms, '0);
        compare_addr("sdram_addr", sdram_addr, '0);
        compare_flag("autorefresh", autorefresh, 1'b0);
        check_ready_rise();
        end_test("reset_ready");
    endtask

    task automatic test_cpu_bytes();
        logic [`SDRAM_AW-1:0] snd_exp;
        logic [`SDRAM_AW-1:0] main_exp;
        logic [15:0]          word;
        logic [31:0]          r;
        for (int k = 0; k < 4; k++) begin
            run_to_slot(4'(k * 4)); // every fourth slot starts with the sound cpu
            r = rand_word();
            snd_addr = {r[`SND_AW-1:1], k[0]};
            r = rand_word();
            main_addr = {r[`MAIN_AW-1:1], k[1]}; // all four lane pairs
            snd_exp  = `SND_OFFSET + (snd_addr >> 1);
            main_exp = main_addr >> 1;
            next_enable();
            compare_addr("sdram_addr snd", sdram_addr, snd_exp);
            next_enable();
            compare_addr("sdram_addr main", sdram_addr, main_exp);
            word = model_word(snd_exp);
            compare_byte("snd_dout", roms.snd_dout, k[0] ? word[7:0] : word[15:8]);
            next_enable();
            word = model_word(main_exp);
            compare_byte("main_dout", roms.main_dout, k[1] ? word[7:0] : word[15:8]);
        end
        end_test("cpu_bytes");
    endtask

    task automatic test_char_obj();
        logic [`SDRAM_AW-1:0] char_exp;
        logic [`SDRAM_AW-1:0] obj_exp;
        logic [31:0]          r;
        for (int k = 0; k < 2; k++) begin
            run_to_slot(4'd2);
            r = rand_word();
            char_addr = r[`CHAR_AW-1:0];
            obj_addr  = r[31:32-`OBJ_AW];
            char_exp  = `CHAR_OFFSET + char_addr;
            obj_exp   = `OBJ_OFFSET + obj_addr;
            next_enable();
            compare_addr("sdram_addr char", sdram_addr, char_exp);
            next_enable();
            compare_addr("sdram_addr obj", sdram_addr, obj_exp);
            compare_word("char_dout", roms.char_dout, model_word(char_exp));
            next_enable();
            compare_word("obj_dout", roms.obj_dout, model_word(obj_exp));
            // second sprite read of the group
            r = rand_word();
            obj_addr = r[`OBJ_AW-1:0];
            obj_exp  = `OBJ_OFFSET + obj_addr;
            run_to_slot(4'd11);
            next_enable();
            compare_addr("sdram_addr obj", sdram_addr, obj_exp);
            next_enable();
            compare_word("obj_dout", roms.obj_dout, model_word(obj_exp));
        end
        end_test("char_obj");
    endtask

    task automatic test_scroll();
        logic [`SDRAM_AW-1:0] lo_exp;
        logic [`SDRAM_AW-1:0] hi_exp;
        logic [15:0]          hi_word;
        logic [31:0]          r;
        for (int k = 0; k < 3; k++) begin
            run_to_slot(4'd6);
            r = rand_word();
            scr_addr = r[`SCR_AW-1:0];
            lo_exp   = `SCR_OFFSET + scr_addr;
            hi_exp   = lo_exp + `SCR2_OFFSET; // second word follows the first address
            next_enable();
            compare_addr("sdram_addr scr_lo", sdram_addr, lo_exp);
            next_enable();
            compare_addr("sdram_addr scr_hi", sdram_addr, hi_exp);
            next_enable();
            hi_word = model_word(hi_exp);
            compare_scr("scr_dout", roms.scr_dout,
                        {hi_word[15:8] | hi_word[7:0], model_word(lo_exp)});
        end
        end_test("scroll");
    endtask

    task automatic test_refresh();
        logic [3:0] s;
        run_to_slot(4'd0);
        lvbl = 1'b0; // vertical blank
        for (int i = 0; i < 16; i++) begin
            s = slot_num;
            next_enable();
            compare_flag("autorefresh", autorefresh, s inside {4'd2, 4'd6, 4'd7});
        end
        lvbl = 1'b1;
        for (int i = 0; i < 16; i++) begin
            next_enable();
            compare_flag("autorefresh", autorefresh, 1'b0);
        end
        end_test("refresh");
    endtask

    task automatic test_download();
        run_to_slot(4'd5);
        downloading = 1'b1; // mid-frame
        lvbl        = 1'b0; // the scroll slot ahead would ask for refresh
        next_enable();
        next_enable();
        compare_roms("roms", roms, '0);
        compare_addr("sdram_addr", sdram_addr, '0);
        compare_flag("ready", ready, 1'b0);
        compare_flag("autorefresh", autorefresh, 1'b0);
        downloading = 1'b0;
        lvbl        = 1'b1;
        check_ready_rise();
        end_test("download");
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        cen            = 1'b0;
        h              = '0;
        hsub           = 1'b0;
        lvbl           = 1'b1; // active video, no refresh
        downloading    = 1'b0;
        snd_addr       = '0;
        main_addr      = '0;
        char_addr      = '0;
        obj_addr       = '0;
        scr_addr       = '0;
        slot_num       = '0;
        err_count      = 0;
        test_err_start = 0;
        tests_run      = 0;
        tests_failed   = 0;
        cycle_count    = 0;

        test_reset_ready();
        test_cpu_bytes();
        test_char_obj();
        test_scroll();
        test_refresh();
        test_download();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
rom_slot_pkg.sv
rom_slot_decode.sv
rom_addr_issue.sv
rom_data_capture.sv
rom_slot_top.sv
tb_sdram_model.sv
tb_rom_slot.sv

// ==== Bender.yml ====
package:
  name: rom_slot

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rom_slot_pkg.sv
      - rom_slot_decode.sv
      - rom_addr_issue.sv
      - rom_data_capture.sv
      - rom_slot_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sdram_model.sv
      - tb_rom_slot.sv
